//--- common/addrgen_pkg.sv
`default_nettype none

package addrgen_pkg;

  ////////////////////////////////////////
  // Widths and depths
  ////////////////////////////////////////

  // Byte address width on the memory bus
  localparam int unsigned AddrWidth    = 32;
  // Operand word from the register file
  localparam int unsigned ElenWidth    = 64;
  // Vector length counter
  localparam int unsigned VlWidth      = 16;
  // 8 bytes per bus beat
  localparam int unsigned BusBytesLog  = 3;
  localparam int unsigned AxiLenWidth  = 8;
  // Descriptor queue towards the load/store units
  localparam int unsigned QueueDepth   = 4;
  // Computed gather/scatter addresses waiting for the generator
  localparam int unsigned IdxBufDepth  = 2;
  // Selects one sub-word of an operand word
  localparam int unsigned ElemPtrWidth = $clog2(ElenWidth / 8);

  ////////////////////////////////////////
  // Types
  ////////////////////////////////////////

  typedef logic [AddrWidth-1:0]   addr_t;
  typedef logic [ElenWidth-1:0]   elen_t;
  typedef logic [VlWidth-1:0]     vlen_t;
  typedef logic [AxiLenWidth-1:0] axi_len_t;
  typedef logic [2:0]             axi_size_t;

  // Value equals log2 of the bytes per element
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  // Unit-stride, strided and indexed loads and stores
  typedef enum logic [2:0] {
    OP_VLE,
    OP_VSE,
    OP_VLSE,
    OP_VSSE,
    OP_VLXE,
    OP_VSXE
  } mem_op_e;

  // One entry per AR/AW request, consumed by the load or store unit
  typedef struct packed {
    addr_t     addr;
    axi_len_t  len;
    axi_size_t size;
    logic      is_load;
  } ls_req_t;

  // True when the address is not a multiple of the element size
  function automatic logic is_addr_error(addr_t addr, vew_e vew);
    return |(addr & ((addr_t'(1) << vew) - addr_t'(1)));
  endfunction

endpackage

`default_nettype wire

//--- hw/req_queue.sv
`default_nettype none

module req_queue #(
  parameter type         payload_t = logic,
  parameter int unsigned Depth     = 2
) (
  input  wire logic     clk_i,
  input  wire logic     rst_ni,
  input  wire logic     push_i,
  input  wire payload_t data_i,
  output logic          full_o,
  input  wire logic     pop_i,
  output payload_t      data_o,
  output logic          empty_o
);

  // Entry storage
  payload_t mem_q [Depth];

  logic [$clog2(Depth)-1:0] wr_ptr_q, rd_ptr_q;
  logic [$clog2(Depth):0]   cnt_q;
  logic                     do_push, do_pop;

  assign full_o  = int'(cnt_q) == Depth;
  assign empty_o = cnt_q == '0;
  assign data_o  = mem_q[rd_ptr_q];

  // A pop on empty is dropped and a push on full never happens
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (int'(wr_ptr_q) == Depth - 1) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (int'(rd_ptr_q) == Depth - 1) ? '0 : rd_ptr_q + 1'b1;
      end
      // Occupancy only moves when exactly one side acts
      case ({do_push, do_pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // Producers must respect full_o or an entry is lost
  assert property (@(posedge clk_i) disable iff (!rst_ni) !(push_i && full_o));

endmodule

`default_nettype wire

//--- addrgen/insn_sequencer.sv
`default_nettype none

module insn_sequencer import addrgen_pkg::*; (
  input  wire logic    clk_i,
  input  wire logic    rst_ni,
  // Instruction from the issuer
  input  wire logic    pe_req_valid_i,
  input  wire mem_op_e pe_op_i,
  input  wire addr_t   pe_addr_i,
  input  wire addr_t   pe_stride_i,
  input  wire vlen_t   pe_vl_i,
  input  wire vew_e    pe_eew_idx_i,
  input  wire vew_e    pe_vew_i,
  // Request towards the AXI request generator
  input  wire logic    req_done_i,
  input  wire logic    idx_error_i,
  output logic         req_valid_o,
  output addr_t        req_addr_o,
  output vlen_t        req_len_o,
  output addr_t        req_stride_o,
  output vew_e         req_vew_o,
  output logic         req_is_load_o,
  output logic         req_is_burst_o,
  output logic         req_is_indexed_o,
  // Index unit start
  output logic         idx_start_o,
  output addr_t        idx_base_o,
  output vew_e         idx_eew_o,
  output vlen_t        idx_vl_o,
  // Completion
  output logic         ack_o,
  output logic         error_o
);

  typedef enum logic [1:0] {
    IDLE,
    ADDRGEN,
    ADDRGEN_IDX,
    ADDRGEN_IDX_END
  } state_e;

  state_e state_q, state_d;

  // Latched instruction
  mem_op_e op_q;
  addr_t   addr_q, stride_q;
  vlen_t   vl_q;
  vew_e    vew_q, eew_q;
  logic    latch;

  logic    ack_d, err_d, idx_start_d;
  logic    ack_q, err_q, idx_start_q;

  ////////////////////////////////////////
  // Instruction FSM
  ////////////////////////////////////////

  always_comb begin
    state_d     = state_q;
    latch       = 1'b0;
    ack_d       = 1'b0;
    err_d       = 1'b0;
    idx_start_d = 1'b0;
    req_valid_o = 1'b0;
    case (state_q)
      IDLE: begin
        // Strobes while busy are simply not looked at
        if (pe_req_valid_i) begin
          latch = 1'b1;
          if (pe_op_i inside {OP_VLXE, OP_VSXE}) begin
            state_d     = ADDRGEN_IDX;
            idx_start_d = 1'b1;
          end else begin
            state_d = ADDRGEN;
          end
        end
      end
      ADDRGEN: begin
        // A misaligned base ends here and nothing reaches the bus
        if (is_addr_error(addr_q, vew_q)) begin
          ack_d   = 1'b1;
          err_d   = 1'b1;
          state_d = IDLE;
        end else begin
          req_valid_o = 1'b1;
          if (req_done_i) begin
            ack_d   = 1'b1;
            state_d = IDLE;
          end
        end
      end
      ADDRGEN_IDX: begin
        // Any element may fault, so hold until the generator reports
        req_valid_o = 1'b1;
        if (req_done_i || idx_error_i) begin
          ack_d   = 1'b1;
          err_d   = idx_error_i;
          state_d = ADDRGEN_IDX_END;
        end
      end
      // Ack is visible here
      default: state_d = IDLE;
    endcase
  end

  // Payload of the instruction
  always_ff @(posedge clk_i) begin
    if (latch) begin
      op_q     <= pe_op_i;
      addr_q   <= pe_addr_i;
      stride_q <= pe_stride_i;
      vl_q     <= pe_vl_i;
      vew_q    <= pe_vew_i;
      eew_q    <= pe_eew_idx_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= IDLE;
      ack_q       <= 1'b0;
      err_q       <= 1'b0;
      idx_start_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      ack_q       <= ack_d;
      err_q       <= err_d;
      idx_start_q <= idx_start_d;
    end
  end

  assign req_addr_o       = addr_q;
  assign req_len_o        = vl_q;
  assign req_stride_o     = stride_q;
  assign req_vew_o        = vew_q;
  assign req_is_load_o    = op_q inside {OP_VLE, OP_VLSE, OP_VLXE};
  // Unit-stride turns into a single incrementing burst
  assign req_is_burst_o   = op_q inside {OP_VLE, OP_VSE};
  assign req_is_indexed_o = op_q inside {OP_VLXE, OP_VSXE};

  assign idx_start_o = idx_start_q;
  assign idx_base_o  = addr_q;
  assign idx_eew_o   = eew_q;
  assign idx_vl_o    = vl_q;

  assign ack_o   = ack_q;
  assign error_o = err_q;

  // The issuer waits for ack, so completions never come back to back
  assert property (@(posedge clk_i) disable iff (!rst_ni) ack_o |=> !ack_o);

endmodule

`default_nettype wire

//--- addrgen/index_unit.sv
`default_nettype none

module index_unit import addrgen_pkg::*; (
  input  wire logic  clk_i,
  input  wire logic  rst_ni,
  input  wire logic  idx_start_i,
  input  wire addr_t idx_base_i,
  input  wire vew_e  idx_eew_i,
  input  wire vlen_t idx_vl_i,
  // Index words from the register file
  input  wire elen_t operand_i,
  input  wire logic  operand_valid_i,
  output logic       operand_ready_o,
  // Index address buffer towards the generator
  input  wire logic  idx_pop_i,
  output addr_t      idx_addr_o,
  output logic       idx_valid_o
);

  logic                    busy_q;
  addr_t                   base_q;
  vew_e                    eew_q;
  vlen_t                   cnt_q;
  logic [ElemPtrWidth-1:0] elm_ptr_q, last_subw_q;

  elen_t idx_word;
  addr_t idx_sum;
  logic  buf_full, buf_empty, push;

  // Pick the current sub-word, zero extended
  always_comb begin
    case (eew_q)
      EW8:     idx_word = elen_t'(operand_i[8*elm_ptr_q +: 8]);
      EW16:    idx_word = elen_t'(operand_i[16*elm_ptr_q[1:0] +: 16]);
      EW32:    idx_word = elen_t'(operand_i[32*elm_ptr_q[0] +: 32]);
      default: idx_word = operand_i;
    endcase
  end

  assign idx_sum = base_q + addr_t'(idx_word);

  // A start always wins over leftovers of an aborted instruction
  assign push = busy_q && operand_valid_i && !buf_full && !idx_start_i;

  // Word is done at its last sub-word or at the last element
  assign operand_ready_o = push && ((elm_ptr_q == last_subw_q) || (cnt_q == vlen_t'(1)));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q      <= 1'b0;
      base_q      <= '0;
      eew_q       <= EW8;
      cnt_q       <= '0;
      elm_ptr_q   <= '0;
      last_subw_q <= '0;
    end else if (idx_start_i) begin
      busy_q      <= idx_vl_i != '0;
      base_q      <= idx_base_i;
      eew_q       <= idx_eew_i;
      cnt_q       <= idx_vl_i;
      elm_ptr_q   <= '0;
      // 7, 3, 1 or 0 for 8, 16, 32 or 64 bit indices
      last_subw_q <= ElemPtrWidth'(7 >> idx_eew_i);
    end else if (push) begin
      cnt_q     <= cnt_q - 1'b1;
      elm_ptr_q <= operand_ready_o ? '0 : elm_ptr_q + 1'b1;
      if (cnt_q == vlen_t'(1)) begin
        busy_q <= 1'b0;
      end
    end
  end

  req_queue #(
    .payload_t(addr_t),
    .Depth    (IdxBufDepth)
  ) i_idx_buf (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .push_i (push),
    .data_i (idx_sum),
    .full_o (buf_full),
    .pop_i  (idx_pop_i),
    .data_o (idx_addr_o),
    .empty_o(buf_empty)
  );

  assign idx_valid_o = !buf_empty;

endmodule

`default_nettype wire

//--- addrgen/axi_req_gen.sv
`default_nettype none

module axi_req_gen import addrgen_pkg::*; (
  input  wire logic  clk_i,
  input  wire logic  rst_ni,
  // Request from the sequencer
  input  wire logic  req_valid_i,
  input  wire addr_t req_addr_i,
  input  wire vlen_t req_len_i,
  input  wire addr_t req_stride_i,
  input  wire vew_e  req_vew_i,
  input  wire logic  req_is_load_i,
  input  wire logic  req_is_burst_i,
  input  wire logic  req_is_indexed_i,
  output logic       req_done_o,
  output logic       idx_error_o,
  // Index address buffer
  input  wire addr_t idx_addr_i,
  input  wire logic  idx_valid_i,
  output logic       idx_pop_o,
  // AR and AW address strobes
  input  wire logic  ar_ready_i,
  output logic       ar_valid_o,
  output addr_t      ar_addr_o,
  output axi_len_t   ar_len_o,
  output axi_size_t  ar_size_o,
  input  wire logic  aw_ready_i,
  output logic       aw_valid_o,
  output addr_t      aw_addr_o,
  output axi_len_t   aw_len_o,
  output axi_size_t  aw_size_o,
  // Descriptor queue towards the load/store units
  input  wire logic  ldu_ready_i,
  input  wire logic  stu_ready_i,
  output ls_req_t    ls_req_o,
  output logic       ls_req_valid_o,
  output vlen_t      error_vl_o
);

  // Latched request
  logic  busy_q;
  addr_t addr_q, stride_q;
  vlen_t len_q, total_q;
  vew_e  vew_q;
  logic  is_load_q, is_burst_q, is_indexed_q;

  logic [VlWidth+2:0] burst_bytes;
  axi_len_t           beat_len;
  axi_size_t          beat_size;
  addr_t              cur_addr;
  logic               have_addr, order_ok, ax_ready, fire, idx_err;
  logic               q_full, q_empty;
  ls_req_t            q_data;

  ////////////////////////////////////////
  // Beat shape and issue condition
  ////////////////////////////////////////

  // Whole vector in one burst of 8 byte beats
  assign burst_bytes = (VlWidth+3)'(len_q) << vew_q;
  assign beat_len    = is_burst_q ? axi_len_t'((burst_bytes - 1'b1) >> BusBytesLog) : '0;
  assign beat_size   = is_burst_q ? axi_size_t'(BusBytesLog) : axi_size_t'(vew_q);
  assign cur_addr    = is_indexed_q ? idx_addr_i : addr_q;

  assign have_addr = !is_indexed_q || idx_valid_i;
  // Do not mix directions in the queue
  assign order_ok  = q_empty || (ls_req_o.is_load == is_load_q);
  assign ax_ready  = is_load_q ? ar_ready_i : aw_ready_i;
  assign fire      = busy_q && have_addr && order_ok && !q_full && ax_ready;

  assign ar_valid_o = fire && is_load_q;
  assign aw_valid_o = fire && !is_load_q;
  assign ar_addr_o  = cur_addr;
  assign aw_addr_o  = cur_addr;
  assign ar_len_o   = beat_len;
  assign aw_len_o   = beat_len;
  assign ar_size_o  = beat_size;
  assign aw_size_o  = beat_size;

  // Faulting element is still issued, then the instruction stops
  assign idx_err     = fire && is_indexed_q && is_addr_error(idx_addr_i, vew_q);
  assign idx_error_o = idx_err;
  assign req_done_o  = fire && (is_burst_q || len_q == vlen_t'(1) || idx_err);

  // While idle, stale addresses left by a faulted gather are dropped
  assign idx_pop_o = busy_q ? (fire && is_indexed_q) : idx_valid_i;

  assign q_data = '{addr: cur_addr, len: beat_len, size: beat_size, is_load: is_load_q};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q     <= 1'b0;
      error_vl_o <= '0;
    end else begin
      if (!busy_q) begin
        busy_q <= req_valid_i;
      end else if (req_done_o) begin
        busy_q <= 1'b0;
      end
      // Position of the faulting element within the vector
      if (idx_err) begin
        error_vl_o <= total_q - len_q;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!busy_q && req_valid_i) begin
      addr_q       <= req_addr_i;
      stride_q     <= req_stride_i;
      len_q        <= req_len_i;
      total_q      <= req_len_i;
      vew_q        <= req_vew_i;
      is_load_q    <= req_is_load_i;
      is_burst_q   <= req_is_burst_i;
      is_indexed_q <= req_is_indexed_i;
    end else if (fire) begin
      // Step to the next strided element
      len_q  <= len_q - 1'b1;
      addr_q <= addr_q + stride_q;
    end
  end

  req_queue #(
    .payload_t(ls_req_t),
    .Depth    (QueueDepth)
  ) i_ls_queue (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .push_i (fire),
    .data_i (q_data),
    .full_o (q_full),
    .pop_i  (ldu_ready_i || stu_ready_i),
    .data_o (ls_req_o),
    .empty_o(q_empty)
  );

  assign ls_req_valid_o = !q_empty;

  assert property (@(posedge clk_i) disable iff (!rst_ni) !(ar_valid_o && aw_valid_o));

endmodule

`default_nettype wire

//--- addrgen/addrgen_top.sv
`default_nettype none

module addrgen_top import addrgen_pkg::*; (
  input  wire logic    clk_i,
  input  wire logic    rst_ni,
  // Instruction interface
  input  wire logic    pe_req_valid_i,
  input  wire mem_op_e pe_op_i,
  input  wire addr_t   pe_addr_i,
  input  wire addr_t   pe_stride_i,
  input  wire vlen_t   pe_vl_i,
  input  wire vew_e    pe_vew_i,
  input  wire vew_e    pe_eew_idx_i,
  output logic         ack_o,
  output logic         error_o,
  output vlen_t        error_vl_o,
  // Index operands
  input  wire elen_t   operand_i,
  input  wire logic    operand_valid_i,
  output logic         operand_ready_o,
  // Memory bus addresses
  output logic         ar_valid_o,
  output addr_t        ar_addr_o,
  output axi_len_t     ar_len_o,
  output axi_size_t    ar_size_o,
  input  wire logic    ar_ready_i,
  output logic         aw_valid_o,
  output addr_t        aw_addr_o,
  output axi_len_t     aw_len_o,
  output axi_size_t    aw_size_o,
  input  wire logic    aw_ready_i,
  // Load/store unit descriptors
  output ls_req_t      ls_req_o,
  output logic         ls_req_valid_o,
  input  wire logic    ldu_ready_i,
  input  wire logic    stu_ready_i
);

  ////////////////////////////////////////
  // Sequencer to generator and index unit
  ////////////////////////////////////////

  logic  req_valid, req_done, idx_error;
  addr_t req_addr, req_stride;
  vlen_t req_len;
  vew_e  req_vew;
  logic  req_is_load, req_is_burst, req_is_indexed;

  logic  idx_start;
  addr_t idx_base;
  vew_e  idx_eew;
  vlen_t idx_vl;

  addr_t idx_addr;
  logic  idx_valid, idx_pop;

  insn_sequencer i_insn_sequencer (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .pe_req_valid_i  (pe_req_valid_i),
    .pe_op_i         (pe_op_i),
    .pe_addr_i       (pe_addr_i),
    .pe_stride_i     (pe_stride_i),
    .pe_vl_i         (pe_vl_i),
    .pe_eew_idx_i    (pe_eew_idx_i),
    .pe_vew_i        (pe_vew_i),
    .req_done_i      (req_done),
    .idx_error_i     (idx_error),
    .req_valid_o     (req_valid),
    .req_addr_o      (req_addr),
    .req_len_o       (req_len),
    .req_stride_o    (req_stride),
    .req_vew_o       (req_vew),
    .req_is_load_o   (req_is_load),
    .req_is_burst_o  (req_is_burst),
    .req_is_indexed_o(req_is_indexed),
    .idx_start_o     (idx_start),
    .idx_base_o      (idx_base),
    .idx_eew_o       (idx_eew),
    .idx_vl_o        (idx_vl),
    .ack_o           (ack_o),
    .error_o         (error_o)
  );

  index_unit i_index_unit (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .idx_start_i    (idx_start),
    .idx_base_i     (idx_base),
    .idx_eew_i      (idx_eew),
    .idx_vl_i       (idx_vl),
    .operand_i      (operand_i),
    .operand_valid_i(operand_valid_i),
    .operand_ready_o(operand_ready_o),
    .idx_pop_i      (idx_pop),
    .idx_addr_o     (idx_addr),
    .idx_valid_o    (idx_valid)
  );

  axi_req_gen i_axi_req_gen (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_valid_i     (req_valid),
    .req_addr_i      (req_addr),
    .req_len_i       (req_len),
    .req_stride_i    (req_stride),
    .req_vew_i       (req_vew),
    .req_is_load_i   (req_is_load),
    .req_is_burst_i  (req_is_burst),
    .req_is_indexed_i(req_is_indexed),
    .req_done_o      (req_done),
    .idx_error_o     (idx_error),
    .idx_addr_i      (idx_addr),
    .idx_valid_i     (idx_valid),
    .idx_pop_o       (idx_pop),
    .ar_ready_i      (ar_ready_i),
    .ar_valid_o      (ar_valid_o),
    .ar_addr_o       (ar_addr_o),
    .ar_len_o        (ar_len_o),
    .ar_size_o       (ar_size_o),
    .aw_ready_i      (aw_ready_i),
    .aw_valid_o      (aw_valid_o),
    .aw_addr_o       (aw_addr_o),
    .aw_len_o        (aw_len_o),
    .aw_size_o       (aw_size_o),
    .ldu_ready_i     (ldu_ready_i),
    .stu_ready_i     (stu_ready_i),
    .ls_req_o        (ls_req_o),
    .ls_req_valid_o  (ls_req_valid_o),
    .error_vl_o      (error_vl_o)
  );

endmodule

`default_nettype wire

//--- tests/tb_addrgen_tests.svh
`ifndef TB_ADDRGEN_TESTS_SVH
`define TB_ADDRGEN_TESTS_SVH

// Forget everything recorded by the monitors
task automatic clear_records();
  ax_dir_q.delete();
  ax_addr_q.delete();
  ax_len_q.delete();
  ax_size_q.delete();
  pops_q.delete();
  ack_seen = 1'b0;
  ready_pulses = 0;
endtask

task automatic issue(mem_op_e op, addr_t addr, addr_t stride, vlen_t vl, vew_e vew, vew_e eew);
  @(negedge clk_i);
  pe_req_valid_i = 1'b1;
  pe_op_i = op;
  pe_addr_i = addr;
  pe_stride_i = stride;
  pe_vl_i = vl;
  pe_vew_i = vew;
  pe_eew_idx_i = eew;
  @(negedge clk_i);
  pe_req_valid_i = 1'b0;
endtask

task automatic wait_ack();
  int n;
  n = 0;
  while (!ack_seen && n < Timeout) begin
    @(negedge clk_i);
    n++;
  end
  if (!ack_seen) begin
    errors++;
    $display("Timeout while waiting for the instruction ack");
  end
endtask

// Queue and operands empty
task automatic wait_drain();
  int n;
  n = 0;
  while ((ls_req_valid_o || opnd_q.size() != 0) && n < Timeout) begin
    @(negedge clk_i);
    n++;
  end
  if (ls_req_valid_o || opnd_q.size() != 0) begin
    errors++;
    $display("Timeout while waiting for the descriptor queue to drain");
  end
endtask

// Compare one recorded transfer and its descriptor
task automatic check_xfer(int i, logic is_load, addr_t addr, axi_len_t len, axi_size_t size);
  ls_req_t exp;
  exp = '{addr: addr, len: len, size: size, is_load: is_load};
  if (i >= ax_addr_q.size() || i >= pops_q.size()) begin
    errors++;
    $display("Transfer %0d is missing", i);
  end else begin
    check_bit("ax_dir", ax_dir_q[i], is_load);
    check_addr("ax_addr", ax_addr_q[i], addr);
    check_len("ax_len", ax_len_q[i], len);
    check_size("ax_size", ax_size_q[i], size);
    check_ls_req("ls_req", pops_q[i], exp);
  end
endtask

task automatic check_count(string name, int got, int exp);
  if (got != exp) begin
    errors++;
    $display("ERROR %0t %s got %0d expected %0d", $time, name, got, exp);
  end
endtask

task automatic check_after_reset();
  check_bit("ack_o", ack_o, 1'b0);
  check_bit("error_o", error_o, 1'b0);
  check_bit("ar_valid_o", ar_valid_o, 1'b0);
  check_bit("aw_valid_o", aw_valid_o, 1'b0);
  check_bit("operand_ready_o", operand_ready_o, 1'b0);
  check_bit("ls_req_valid_o", ls_req_valid_o, 1'b0);
  check_vl("error_vl_o", error_vl_o, '0);
endtask

task automatic load_unit_stride();
  int bytes;
  clear_records();
  issue(OP_VLE, 32'h1000, '0, 16'd10, EW32, EW8);
  wait_ack();
  wait_drain();
  check_bit("error_o", ack_err, 1'b0);
  check_count("transfer count", ax_addr_q.size(), 1);
  check_count("descriptor count", pops_q.size(), 1);
  // 10 words of 4 bytes in 8 byte beats
  bytes = 10 * 4;
  check_xfer(0, 1'b1, 32'h1000, axi_len_t'((bytes + 7) / 8 - 1), 3'd3);
endtask

task automatic store_strided();
  clear_records();
  issue(OP_VSSE, 32'h2000, 32'd24, 16'd5, EW64, EW8);
  wait_ack();
  wait_drain();
  check_bit("error_o", ack_err, 1'b0);
  check_count("transfer count", ax_addr_q.size(), 5);
  check_count("descriptor count", pops_q.size(), 5);
  for (int i = 0; i < 5; i++) begin
    check_xfer(i, 1'b0, 32'h2000 + 24 * i, '0, 3'd3);
  end
endtask

task automatic reject_misaligned_base();
  clear_records();
  issue(OP_VLSE, 32'h3002, 32'd4, 16'd4, EW32, EW8);
  wait_ack();
  check_bit("error_o", ack_err, 1'b1);
  check_count("ack latency", ack_cycle - strobe_cycle, 2);
  check_count("transfer count", ax_addr_q.size(), 0);
  check_count("descriptor count", pops_q.size(), 0);
endtask

task automatic gather_load();
  logic [15:0] idx [8];
  elen_t       word;
  clear_records();
  for (int w = 0; w < 2; w++) begin
    for (int j = 0; j < 4; j++) begin
      idx[4*w+j] = 16'(rand_bits(16));
      word[16*j +: 16] = idx[4*w+j];
    end
    opnd_q.push_back(word);
  end
  issue(OP_VLXE, 32'h0001_0000, '0, 16'd8, EW8, EW16);
  wait_ack();
  wait_drain();
  check_bit("error_o", ack_err, 1'b0);
  check_count("transfer count", ax_addr_q.size(), 8);
  check_count("descriptor count", pops_q.size(), 8);
  for (int i = 0; i < 8; i++) begin
    check_xfer(i, 1'b1, 32'h0001_0000 + {16'h0, idx[i]}, '0, 3'd0);
  end
  // Two words of four indices each
  check_count("operand_ready_o pulses", ready_pulses, 2);
endtask

task automatic scatter_store_fault();
  logic [31:0] idx [6];
  clear_records();
  for (int i = 0; i < 6; i++) begin
    idx[i] = 32'(16 * i);
  end
  // Element 3 is off by two bytes
  idx[3] = 32'h32;
  for (int w = 0; w < 3; w++) begin
    opnd_q.push_back({idx[2*w+1], idx[2*w]});
  end
  issue(OP_VSXE, 32'h8000, '0, 16'd6, EW32, EW32);
  wait_ack();
  wait_drain();
  check_bit("error_o", ack_err, 1'b1);
  check_vl("error_vl_o", error_vl_o, 16'd3);
  check_count("transfer count", ax_addr_q.size(), 4);
  check_count("descriptor count", pops_q.size(), 4);
  for (int i = 0; i < 4; i++) begin
    check_xfer(i, 1'b0, 32'h8000 + idx[i], '0, 3'd2);
  end
endtask

task automatic order_directions();
  clear_records();
  hold_ls = 1'b1;
  issue(OP_VLSE, 32'h4000, 32'd8, 16'd3, EW64, EW8);
  wait_ack();
  ack_seen = 1'b0;
  issue(OP_VSSE, 32'h5000, 32'd8, 16'd2, EW64, EW8);
  repeat (20) @(negedge clk_i);
  // Loads still queued, so the store must wait
  check_count("transfer count", ax_addr_q.size(), 3);
  hold_ls = 1'b0;
  wait_ack();
  wait_drain();
  check_bit("error_o", ack_err, 1'b0);
  check_count("transfer count", ax_addr_q.size(), 5);
  check_count("descriptor count", pops_q.size(), 5);
  for (int i = 0; i < 3; i++) begin
    check_xfer(i, 1'b1, 32'h4000 + 8 * i, '0, 3'd3);
  end
  for (int i = 0; i < 2; i++) begin
    check_xfer(3 + i, 1'b0, 32'h5000 + 8 * i, '0, 3'd3);
  end
endtask

`endif

//--- tests/tb_addrgen.sv
`default_nettype none

module tb_addrgen import addrgen_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned Timeout = 500;

  logic    clk_i, rst_ni;
  logic    pe_req_valid_i;
  mem_op_e pe_op_i;
  addr_t   pe_addr_i, pe_stride_i;
  vlen_t   pe_vl_i;
  vew_e    pe_vew_i, pe_eew_idx_i;
  logic    ack_o, error_o;
  vlen_t   error_vl_o;
  elen_t   operand_i;
  logic    operand_valid_i, operand_ready_o;
  logic    ar_valid_o, ar_ready_i, aw_valid_o, aw_ready_i;
  addr_t   ar_addr_o, aw_addr_o;
  axi_len_t  ar_len_o, aw_len_o;
  axi_size_t ar_size_o, aw_size_o;
  ls_req_t ls_req_o;
  logic    ls_req_valid_o, ldu_ready_i, stu_ready_i;

  // Recorded AR/AW transfers in order with dir 1 for AR
  logic      ax_dir_q [$];
  addr_t     ax_addr_q [$];
  axi_len_t  ax_len_q [$];
  axi_size_t ax_size_q [$];
  ls_req_t   pops_q [$];
  elen_t     opnd_q [$];

  int   errors;
  int   cycle_cnt;
  int   strobe_cycle, ack_cycle, ready_pulses;
  logic ack_seen, ack_err;
  logic hold_ls;
  logic [15:0] rdy_lfsr, idx_lfsr;

  addrgen_top addrgen_top_i (.*);

  always #2 clk_i = ~clk_i;

  ////////////////////////////////////////
  // Random source
  ////////////////////////////////////////

  // 16 bit Fibonacci LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // Index values with one step per bit
  function automatic logic [63:0] rand_bits(int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      idx_lfsr = lfsr_step(idx_lfsr);
      v[i] = idx_lfsr[0];
    end
    return v;
  endfunction

  ////////////////////////////////////////
  // Memory side and operand models
  ////////////////////////////////////////

  always @(negedge clk_i) begin
    rdy_lfsr = lfsr_step(rdy_lfsr);
    ar_ready_i = rdy_lfsr[0];
    rdy_lfsr = lfsr_step(rdy_lfsr);
    aw_ready_i = rdy_lfsr[0];
    rdy_lfsr = lfsr_step(rdy_lfsr);
    ldu_ready_i = rdy_lfsr[0] && !hold_ls;
    rdy_lfsr = lfsr_step(rdy_lfsr);
    stu_ready_i = rdy_lfsr[0] && !hold_ls;
    operand_valid_i = opnd_q.size() != 0;
    operand_i = (opnd_q.size() != 0) ? opnd_q[0] : '0;
  end

  // Monitors see pre-edge values
  always @(posedge clk_i) begin
    cycle_cnt++;
    if (rst_ni) begin
      if (pe_req_valid_i) strobe_cycle = cycle_cnt;
      // A strobe without ready would be a lost request
      if (ar_valid_o && !ar_ready_i) begin
        errors++;
        $display("AR request raised at %0t while ar_ready_i was low", $time);
      end
      if (aw_valid_o && !aw_ready_i) begin
        errors++;
        $display("AW request raised at %0t while aw_ready_i was low", $time);
      end
      if (ar_valid_o || aw_valid_o) begin
        ax_dir_q.push_back(ar_valid_o);
        ax_addr_q.push_back(ar_valid_o ? ar_addr_o : aw_addr_o);
        ax_len_q.push_back(ar_valid_o ? ar_len_o : aw_len_o);
        ax_size_q.push_back(ar_valid_o ? ar_size_o : aw_size_o);
      end
      if (ls_req_valid_o && (ldu_ready_i || stu_ready_i)) pops_q.push_back(ls_req_o);
      if (operand_ready_o) begin
        ready_pulses++;
        if (opnd_q.size() != 0) void'(opnd_q.pop_front());
      end
      if (ack_o) begin
        ack_seen = 1'b1;
        ack_err = error_o;
        ack_cycle = cycle_cnt;
      end
    end
  end

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  task automatic check_addr(string name, addr_t got, addr_t exp);
    if (got !== exp) begin
      errors++;
      $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_len(string name, axi_len_t got, axi_len_t exp);
    if (got !== exp) begin
      errors++;
      $display("ERROR %0t %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_size(string name, axi_size_t got, axi_size_t exp);
    if (got !== exp) begin
      errors++;
      $display("ERROR %0t %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_ls_req(string name, ls_req_t got, ls_req_t exp);
    if (got !== exp) begin
      errors++;
      $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_vl(string name, vlen_t got, vlen_t exp);
    if (got !== exp) begin
      errors++;
      $display("ERROR %0t %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      errors++;
      $display("ERROR %0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  `include "tb_addrgen_tests.svh"

  initial begin
    clk_i = 1'b0;
    rst_ni = 1'b0;
    pe_req_valid_i = 1'b0;
    pe_op_i = OP_VLE;
    pe_addr_i = '0;
    pe_stride_i = '0;
    pe_vl_i = '0;
    pe_vew_i = EW8;
    pe_eew_idx_i = EW8;
    operand_i = '0;
    operand_valid_i = 1'b0;
    ar_ready_i = 1'b0;
    aw_ready_i = 1'b0;
    ldu_ready_i = 1'b0;
    stu_ready_i = 1'b0;
    hold_ls = 1'b0;
    rdy_lfsr = 16'd7;
    idx_lfsr = 16'd7;
    errors = 0;
    cycle_cnt = 0;
    repeat (3) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_after_reset();
    load_unit_stride();
    store_strided();
    reject_misaligned_base();
    gather_load();
    scatter_store_fault();
    order_directions();
    $display("Test done with %0d errors", errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
+incdir+tests
common/addrgen_pkg.sv
hw/req_queue.sv
addrgen/insn_sequencer.sv
addrgen/index_unit.sv
addrgen/axi_req_gen.sv
addrgen/addrgen_top.sv
tests/tb_addrgen.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_addrgen -o tb_sim &&
./obj_dir/tb_sim | tee /dev/stderr | grep -q "Verification passed" &&
{ echo "run.sh: PASS"; exit 0; } ||
{ echo "run.sh: FAIL"; exit 1; }
